//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = uart_tb
FILELIST = src.f
OBJ_DIR = obj_dir
PASS_TEXT = Verification passed

SIM = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/uart_pkg.sv
// UART shared definitions
// Register map offsets, status word layout and character framing
// constants used by the serial port blocks

package uart_pkg;

	// Serial character width, 8N1 framing carries one byte
	localparam int CHAR_WIDTH = 8;

	// Byte offsets from the block base address
	// Status register, read only
	localparam logic [31:0] TX_STATUS_OFFSET = 32'd0;

	// Transmit data, write only, low byte sent
	localparam logic [31:0] TX_DATA_OFFSET = 32'd4;

	// Receive data, a read pops the receive FIFO
	localparam logic [31:0] RX_DATA_OFFSET = 32'd8;

	// Status word bit positions
	// Transmitter idle and able to take a character
	localparam int STATUS_TX_READY_BIT = 0;

	// Receive FIFO holds at least one character
	localparam int STATUS_RX_AVAIL_BIT = 1;

	// Sticky flag, a character was dropped on a full FIFO
	localparam int STATUS_RX_OVERFLOW_BIT = 2;

	// Receiver samples taken per bit period
	// Start bit is checked halfway through, at RX_OVERSAMPLE / 2
	localparam int RX_OVERSAMPLE = 8;

endpackage

//--- sim/tb_clock_gen.sv
// Testbench clock source
// Free running clock, starts low, fixed period

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 20
) (
	output logic clk_o
);

	// Half period high, half period low
	initial
	begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

endmodule

//--- sim/uart_assert.sv
// UART protocol assertions
// Idle transmit line, single cycle receive strobe and FIFO pops
// only on a non-empty buffer

`timescale 1ns/1ps

module uart_assert (
	input logic clk,
	input logic reset_i,
	input logic tx_ready_i,
	input logic tx_i,
	input logic rx_char_valid_i,
	input logic fifo_dequeue_i,
	input logic fifo_empty_i
);

	// Line high while idle and in the stop bit just before it
	tx_idle_high: assert property (@(posedge clk) disable iff (reset_i)
		tx_ready_i |-> tx_i && $past(tx_i))
		else $error("tx line low while idle or in the stop bit before it");

	// Receive strobe lasts exactly one cycle
	rx_valid_single: assert property (@(posedge clk) disable iff (reset_i)
		rx_char_valid_i |=> !rx_char_valid_i)
		else $error("rx character strobe held for two cycles");

	// Receive data read only while a character is waiting
	pop_not_empty: assert property (@(posedge clk) disable iff (reset_i)
		fifo_dequeue_i |-> !fifo_empty_i)
		else $error("receive FIFO popped while empty");

endmodule

bind uart uart_assert u_uart_assert (
	.clk             (clk),
	.reset_i         (reset_i),
	.tx_ready_i      (tx_ready),
	.tx_i            (tx_o),
	.rx_char_valid_i (rx_char_valid),
	.fifo_dequeue_i  (rx_fifo_dequeue),
	.fifo_empty_i    (rx_fifo_empty)
);

//--- sim/uart_tb.sv
// UART testbench
// Loops the transmitter back into the receiver and checks the bus
// registers, FIFO ordering, overflow flag and externally driven frames

`timescale 1ns/1ps

module uart_tb;

	localparam logic [31:0] BASE_ADDRESS = 32'h100;
	localparam int CLOCKS_PER_BIT = 16;
	localparam int CLOCK_PERIOD_NS = 20;
	localparam logic [31:0] STATUS_ADDR = BASE_ADDRESS + uart_pkg::TX_STATUS_OFFSET;
	localparam logic [31:0] TX_DATA_ADDR = BASE_ADDRESS + uart_pkg::TX_DATA_OFFSET;
	localparam logic [31:0] RX_DATA_ADDR = BASE_ADDRESS + uart_pkg::RX_DATA_OFFSET;
	localparam int TABLE_LEN = 12;
	localparam int EXT_FRAMES = 4;
	// Status poll limit of about four character times
	localparam int POLL_LIMIT = 20 * CLOCKS_PER_BIT;
	// Twelve bit periods for every character sent plus slack
	localparam int TOTAL_CHARS = TABLE_LEN + 8 + 9 + EXT_FRAMES + 1 + 2;
	localparam int WATCHDOG_NS = TOTAL_CHARS * 12 * CLOCKS_PER_BIT * CLOCK_PERIOD_NS + 40000;

	logic        clk;
	logic        reset;
	logic [31:0] bus_address;
	logic        bus_read_en;
	logic        bus_write_en;
	logic [31:0] bus_write_data;
	logic [31:0] bus_read_data;
	logic        tx_line;
	logic        rx_line;
	logic        ext_rx;
	logic        ext_mode;
	logic [31:0] lfsr_state;
	logic [31:0] rdata;
	logic [7:0]  rand_byte;
	int          error_count;
	int          tests_run;
	int          tests_failed;
	int          test_errors_start;
	string       test_name;

	// Stimulus bytes that must come back zero extended in order
	logic [7:0] byte_table [TABLE_LEN] = '{
		8'h55, 8'haa, 8'h00, 8'hff, 8'h01, 8'h80,
		8'h3c, 8'hc3, 8'h7e, 8'h12, 8'he7, 8'h9d
	};

	tb_clock_gen #(.PERIOD_NS(CLOCK_PERIOD_NS)) u_clock (.clk_o(clk));

	// Loopback unless the testbench owns the line
	assign rx_line = ext_mode ? ext_rx : tx_line;

	uart #(.BASE_ADDRESS(BASE_ADDRESS), .CLOCKS_PER_BIT(CLOCKS_PER_BIT)) u_dut (
		.clk             (clk),
		.reset_i         (reset),
		.io_address_i    (bus_address),
		.io_read_en_i    (bus_read_en),
		.io_write_en_i   (bus_write_en),
		.io_write_data_i (bus_write_data),
		.io_read_data_o  (bus_read_data),
		.tx_o            (tx_line),
		.rx_i            (rx_line)
	);

	// Status layout from the register map
	function automatic logic [31:0] status_word(input logic tx_ready, input logic rx_avail,
		input logic overflow);
		logic [31:0] word;
		word = '0;
		word[uart_pkg::STATUS_TX_READY_BIT] = tx_ready;
		word[uart_pkg::STATUS_RX_AVAIL_BIT] = rx_avail;
		word[uart_pkg::STATUS_RX_OVERFLOW_BIT] = overflow;
		return word;
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// One LFSR step per bit taken
	task automatic take_random_byte(output logic [7:0] value);
		for (int i = 0; i < 8; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			value[i] = lfsr_state[0];
		end
	endtask

	task automatic check_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("Fail at %0t ns: %s expected 0x%08h, got 0x%08h",
				$time, name, expected, actual);
			error_count++;
		end
	endtask

	// Inputs change on the falling edge
	task automatic bus_write(input logic [31:0] address, input logic [31:0] data);
		@(negedge clk);
		bus_address = address;
		bus_write_data = data;
		bus_write_en = 1'b1;
		@(negedge clk);
		bus_write_en = 1'b0;
		bus_address = '0;
	endtask

	// Read data is sampled 1 ns after the falling edge
	task automatic bus_read(input logic [31:0] address, output logic [31:0] data);
		@(negedge clk);
		bus_address = address;
		bus_read_en = 1'b1;
		#1;
		data = bus_read_data;
		@(negedge clk);
		bus_read_en = 1'b0;
		bus_address = '0;
	endtask

	// Poll status until a bit is set
	// Every poll also clears overflow
	task automatic wait_status(input int bit_index, input string label);
		logic [31:0] word;
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < POLL_LIMIT && !seen; i++)
		begin
			bus_read(STATUS_ADDR, word);
			seen = word[bit_index];
		end
		if (!seen)
		begin
			$display("Error at %0t ns: %s never set within %0d status reads",
				$time, label, POLL_LIMIT);
			error_count++;
		end
	endtask

	// Upper write bits are junk and only the low byte is sent
	task automatic send_byte(input logic [7:0] value);
		wait_status(uart_pkg::STATUS_TX_READY_BIT, "tx_ready");
		bus_write(TX_DATA_ADDR, {24'h5a5a5a, value});
	endtask

	// Called on the falling edge right after the accepted write
	// Start bit began at the rising edge before, each bit is sampled mid-bit
	task automatic check_tx_frame(input logic [7:0] value);
		logic [9:0] frame;
		frame = {1'b1, value, 1'b0};
		repeat (CLOCKS_PER_BIT / 2 - 1) @(negedge clk);
		for (int i = 0; i < 10; i++)
		begin
			check_equal("tx_o", {31'h0, frame[i]}, {31'h0, tx_line});
			repeat (CLOCKS_PER_BIT) @(negedge clk);
		end
	endtask

	// Start bit, data LSB first and the chosen stop level
	task automatic drive_frame(input logic [7:0] value, input logic stop_level);
		logic [9:0] frame;
		frame = {stop_level, value, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(negedge clk);
			ext_rx = frame[i];
			repeat (CLOCKS_PER_BIT - 1) @(negedge clk);
		end
		@(negedge clk);
		ext_rx = 1'b1;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors_start = error_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (error_count == test_errors_start)
			$display("Test %0d %s: ok", tests_run, test_name);
		else
		begin
			tests_failed++;
			$display("Test %0d %s: %0d errors", tests_run, test_name,
				error_count - test_errors_start);
		end
	endtask

	// Hang guard
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		bus_address = '0;
		bus_read_en = 1'b0;
		bus_write_en = 1'b0;
		bus_write_data = '0;
		ext_rx = 1'b1;
		ext_mode = 1'b0;
		lfsr_state = 32'h58f6_61f2;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		begin_test("reset status");
		bus_read(STATUS_ADDR, rdata);
		check_equal("status", status_word(1'b1, 1'b0, 1'b0), rdata);
		end_test();

		// One character at a time through the loopback
		begin_test("loopback table");
		for (int i = 0; i < TABLE_LEN; i++)
		begin
			send_byte(byte_table[i]);
			check_tx_frame(byte_table[i]);
			wait_status(uart_pkg::STATUS_RX_AVAIL_BIT, "rx_avail");
			bus_read(RX_DATA_ADDR, rdata);
			check_equal("rx_data", {24'h0, byte_table[i]}, rdata);
		end
		end_test();

		// Fill the FIFO exactly and then drain it
		begin_test("FIFO ordering");
		for (int i = 0; i < 8; i++)
			send_byte(byte_table[i]);
		wait_status(uart_pkg::STATUS_TX_READY_BIT, "tx_ready");
		for (int i = 0; i < 8; i++)
		begin
			bus_read(RX_DATA_ADDR, rdata);
			check_equal("rx_data", {24'h0, byte_table[i]}, rdata);
		end
		bus_read(STATUS_ADDR, rdata);
		check_equal("status", status_word(1'b1, 1'b0, 1'b0), rdata);
		end_test();

		// Ninth character lands on a full FIFO
		begin_test("overflow");
		for (int i = 0; i < 9; i++)
			send_byte(byte_table[i + 2]);
		// Poll that sees overflow set is the first check
		wait_status(uart_pkg::STATUS_RX_OVERFLOW_BIT, "rx_overflow");
		bus_read(STATUS_ADDR, rdata);
		check_equal("status_rx_overflow", 32'h0, {31'h0, rdata[uart_pkg::STATUS_RX_OVERFLOW_BIT]});
		for (int i = 0; i < 8; i++)
		begin
			bus_read(RX_DATA_ADDR, rdata);
			check_equal("rx_data", {24'h0, byte_table[i + 2]}, rdata);
		end
		bus_read(STATUS_ADDR, rdata);
		check_equal("status_rx_avail", 32'h0, {31'h0, rdata[uart_pkg::STATUS_RX_AVAIL_BIT]});
		end_test();

		// Testbench drives rx while the transmitter is idle
		// Both sources are high at the switch so no edge is seen
		begin_test("external receive");
		ext_rx = 1'b1;
		ext_mode = 1'b1;
		for (int f = 0; f < EXT_FRAMES; f++)
		begin
			take_random_byte(rand_byte);
			drive_frame(rand_byte, 1'b1);
			wait_status(uart_pkg::STATUS_RX_AVAIL_BIT, "rx_avail");
			bus_read(RX_DATA_ADDR, rdata);
			check_equal("rx_data", {24'h0, rand_byte}, rdata);
		end
		// Low stop bit drops the character
		take_random_byte(rand_byte);
		drive_frame(rand_byte, 1'b0);
		repeat (2 * CLOCKS_PER_BIT) @(negedge clk);
		bus_read(STATUS_ADDR, rdata);
		check_equal("status_rx_avail", 32'h0, {31'h0, rdata[uart_pkg::STATUS_RX_AVAIL_BIT]});
		ext_mode = 1'b0;
		end_test();

		// Second write lands while the shifter is busy
		begin_test("busy write");
		send_byte(byte_table[3]);
		bus_write(TX_DATA_ADDR, {24'h0, byte_table[4]});
		wait_status(uart_pkg::STATUS_TX_READY_BIT, "tx_ready");
		wait_status(uart_pkg::STATUS_RX_AVAIL_BIT, "rx_avail");
		bus_read(RX_DATA_ADDR, rdata);
		check_equal("rx_data", {24'h0, byte_table[3]}, rdata);
		// Long enough for a wrongly accepted second frame to show up
		repeat (12 * CLOCKS_PER_BIT) @(negedge clk);
		bus_read(STATUS_ADDR, rdata);
		check_equal("status_rx_avail", 32'h0, {31'h0, rdata[uart_pkg::STATUS_RX_AVAIL_BIT]});
		end_test();

		$display("Tests run %0d, tests failed %0d, checks failed %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- src.f
common/uart_pkg.sv
src/sync_fifo.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart.sv
sim/tb_clock_gen.sv
sim/uart_assert.sv
sim/uart_tb.sv

//--- src/sync_fifo.sv
// Synchronous FIFO
// Circular buffer with read and write pointers and an occupancy count
// Head is shown combinationally on value_o

`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 8
) (
	input  logic             clk,
	input  logic             reset_i,
	input  logic             enqueue_i,
	input  logic [WIDTH-1:0] value_i,
	input  logic             dequeue_i,
	output logic [WIDTH-1:0] value_o,
	output logic             empty_o,
	output logic             full_o
);

	localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]       storage [DEPTH];
	logic [ADDR_WIDTH-1:0]  read_ptr;
	logic [ADDR_WIDTH-1:0]  write_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic                   do_enqueue;
	logic                   do_dequeue;

	// Enqueue on full and dequeue on empty are dropped
	assign do_enqueue = enqueue_i && !full_o;
	assign do_dequeue = dequeue_i && !empty_o;

	// Pointers and occupancy
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_enqueue)
				write_ptr <= (write_ptr == ADDR_WIDTH'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;
			if (do_dequeue)
				read_ptr <= (read_ptr == ADDR_WIDTH'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;
			// Both at once leaves the count alone
			if (do_enqueue && !do_dequeue)
				count <= count + 1'b1;
			else if (do_dequeue && !do_enqueue)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_enqueue)
			storage[write_ptr] <= value_i;
	end

	assign value_o = storage[read_ptr];
	assign empty_o = count == '0;
	assign full_o = count == COUNT_WIDTH'(DEPTH);

endmodule

//--- uart/uart.sv
// UART top level
// Decodes the three bus registers, builds the status word, keeps the
// sticky receive overflow flag and connects transmitter, receiver and FIFO

`timescale 1ns/1ps

module uart #(
	parameter logic [31:0] BASE_ADDRESS = 32'h0,
	parameter int CLOCKS_PER_BIT = 16
) (
	input  logic        clk,
	input  logic        reset_i,
	input  logic [31:0] io_address_i,
	input  logic        io_read_en_i,
	input  logic        io_write_en_i,
	input  logic [31:0] io_write_data_i,
	output logic [31:0] io_read_data_o,
	output logic        tx_o,
	input  logic        rx_i
);

	// Absolute register addresses
	localparam logic [31:0] STATUS_ADDR = BASE_ADDRESS + uart_pkg::TX_STATUS_OFFSET;
	localparam logic [31:0] TX_DATA_ADDR = BASE_ADDRESS + uart_pkg::TX_DATA_OFFSET;
	localparam logic [31:0] RX_DATA_ADDR = BASE_ADDRESS + uart_pkg::RX_DATA_OFFSET;

	logic                            tx_enable;
	logic                            tx_ready;
	logic [uart_pkg::CHAR_WIDTH-1:0] rx_char;
	logic                            rx_char_valid;
	logic                            rx_fifo_dequeue;
	logic [uart_pkg::CHAR_WIDTH-1:0] rx_fifo_char;
	logic                            rx_fifo_empty;
	logic                            rx_fifo_full;
	logic                            status_read;
	logic                            rx_overflow;
	logic [31:0]                     status_word;

	// Bus decode, no wait states
	assign tx_enable = io_write_en_i && (io_address_i == TX_DATA_ADDR);
	assign rx_fifo_dequeue = io_read_en_i && (io_address_i == RX_DATA_ADDR);
	assign status_read = io_read_en_i && (io_address_i == STATUS_ADDR);

	// Sticky overflow flag
	// A new drop in the same cycle as a status read keeps it set
	always_ff @(posedge clk)
	begin
		if (reset_i)
			rx_overflow <= 1'b0;
		else if (rx_char_valid && rx_fifo_full)
			rx_overflow <= 1'b1;
		else if (status_read)
			rx_overflow <= 1'b0;
	end

	// Read mux, status at its own address, FIFO head everywhere else
	always_comb
	begin
		status_word = '0;
		status_word[uart_pkg::STATUS_TX_READY_BIT] = tx_ready;
		status_word[uart_pkg::STATUS_RX_AVAIL_BIT] = !rx_fifo_empty;
		status_word[uart_pkg::STATUS_RX_OVERFLOW_BIT] = rx_overflow;
		if (io_address_i == STATUS_ADDR)
			io_read_data_o = status_word;
		else
			io_read_data_o = {{(32 - uart_pkg::CHAR_WIDTH){1'b0}}, rx_fifo_char};
	end

	uart_tx #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) uart_tx (
		.clk         (clk),
		.reset_i     (reset_i),
		.tx_enable_i (tx_enable),
		.tx_char_i   (io_write_data_i[uart_pkg::CHAR_WIDTH-1:0]),
		.tx_ready_o  (tx_ready),
		.tx_o        (tx_o)
	);

	// Receiver runs at RX_OVERSAMPLE ticks per bit
	uart_rx #(.CLOCKS_PER_SAMPLE(CLOCKS_PER_BIT / uart_pkg::RX_OVERSAMPLE)) uart_rx (
		.clk             (clk),
		.reset_i         (reset_i),
		.rx_i            (rx_i),
		.rx_char_o       (rx_char),
		.rx_char_valid_o (rx_char_valid)
	);

	// Eight character receive buffer
	sync_fifo #(.WIDTH(uart_pkg::CHAR_WIDTH), .DEPTH(8)) rx_fifo (
		.clk       (clk),
		.reset_i   (reset_i),
		.enqueue_i (rx_char_valid),
		.value_i   (rx_char),
		.dequeue_i (rx_fifo_dequeue),
		.value_o   (rx_fifo_char),
		.empty_o   (rx_fifo_empty),
		.full_o    (rx_fifo_full)
	);

endmodule

//--- uart/uart_rx.sv
// UART receiver
// Synchronizes the rx line, finds a start edge and samples each bit
// near its middle using RX_OVERSAMPLE ticks per bit, then reports
// the character if the stop bit is high

`timescale 1ns/1ps

module uart_rx #(
	parameter int CLOCKS_PER_SAMPLE = 2
) (
	input  logic                            clk,
	input  logic                            reset_i,
	input  logic                            rx_i,
	output logic [uart_pkg::CHAR_WIDTH-1:0] rx_char_o,
	output logic                            rx_char_valid_o
);

	localparam int DIVIDE_WIDTH = $clog2(CLOCKS_PER_SAMPLE + 1);
	localparam int SAMPLE_WIDTH = $clog2(uart_pkg::RX_OVERSAMPLE);
	localparam int BIT_WIDTH = $clog2(uart_pkg::CHAR_WIDTH);
	localparam int HALF_BIT = uart_pkg::RX_OVERSAMPLE / 2;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t                          state;
	logic                               rx_meta;
	logic                               rx_sync;
	logic                               rx_prev;
	logic [DIVIDE_WIDTH-1:0]            divide_count;
	logic                               sample_tick;
	logic [SAMPLE_WIDTH-1:0]            sample_count;
	logic [BIT_WIDTH-1:0]               bit_count;

	// Two flop synchronizer plus a delayed copy for edge detect
	// Held at idle level in reset so no false edge is seen
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// Free running sample clock divider
	assign sample_tick = divide_count == DIVIDE_WIDTH'(CLOCKS_PER_SAMPLE - 1);

	always_ff @(posedge clk)
	begin
		if (reset_i || sample_tick)
			divide_count <= '0;
		else
			divide_count <= divide_count + 1'b1;
	end

	// Frame FSM
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			state <= RX_IDLE;
			sample_count <= '0;
			bit_count <= '0;
			rx_char_valid_o <= 1'b0;
		end
		else
		begin
			rx_char_valid_o <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					// Falling edge starts a frame
					if (rx_prev && !rx_sync)
					begin
						state <= RX_START;
						sample_count <= '0;
						bit_count <= '0;
					end
				end

				RX_START:
				begin
					if (sample_tick)
					begin
						if (sample_count == SAMPLE_WIDTH'(HALF_BIT - 1))
						begin
							// Glitch if the line is already back high
							state <= rx_sync ? RX_IDLE : RX_DATA;
							sample_count <= '0;
						end
						else
							sample_count <= sample_count + 1'b1;
					end
				end

				RX_DATA:
				begin
					if (sample_tick)
					begin
						sample_count <= sample_count + 1'b1;
						if (sample_count == SAMPLE_WIDTH'(uart_pkg::RX_OVERSAMPLE - 1))
						begin
							bit_count <= bit_count + 1'b1;
							if (bit_count == BIT_WIDTH'(uart_pkg::CHAR_WIDTH - 1))
								state <= RX_STOP;
						end
					end
				end

				RX_STOP:
				begin
					if (sample_tick)
					begin
						sample_count <= sample_count + 1'b1;
						if (sample_count == SAMPLE_WIDTH'(uart_pkg::RX_OVERSAMPLE - 1))
						begin
							// Framing error drops the character
							rx_char_valid_o <= rx_sync;
							state <= RX_IDLE;
						end
					end
				end

				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// Data shifter with the LSB arriving first
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && sample_tick
			&& sample_count == SAMPLE_WIDTH'(uart_pkg::RX_OVERSAMPLE - 1))
			rx_char_o <= {rx_sync, rx_char_o[uart_pkg::CHAR_WIDTH-1:1]};
	end

endmodule

//--- uart/uart_tx.sv
// UART transmitter
// Frames one character with start and stop bits and shifts it out
// LSB first, one bit every CLOCKS_PER_BIT cycles

`timescale 1ns/1ps

module uart_tx #(
	parameter int CLOCKS_PER_BIT = 16
) (
	input  logic                            clk,
	input  logic                            reset_i,
	input  logic                            tx_enable_i,
	input  logic [uart_pkg::CHAR_WIDTH-1:0] tx_char_i,
	output logic                            tx_ready_o,
	output logic                            tx_o
);

	// Start bit, data bits, stop bit
	localparam int FRAME_BITS = uart_pkg::CHAR_WIDTH + 2;
	localparam int PERIOD_WIDTH = $clog2(CLOCKS_PER_BIT + 1);
	localparam int BIT_COUNT_WIDTH = $clog2(FRAME_BITS);

	logic                       busy;
	logic [FRAME_BITS-1:0]      shift_q;
	logic [PERIOD_WIDTH-1:0]    period_count;
	logic [BIT_COUNT_WIDTH-1:0] bit_count;
	logic                       period_done;

	assign period_done = period_count == PERIOD_WIDTH'(CLOCKS_PER_BIT - 1);

	// Control state
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			busy <= 1'b0;
			period_count <= '0;
			bit_count <= '0;
		end
		else if (!busy)
		begin
			// Writes while busy never reach this branch
			if (tx_enable_i)
			begin
				busy <= 1'b1;
				period_count <= '0;
				bit_count <= '0;
			end
		end
		else if (period_done)
		begin
			period_count <= '0;
			// Last bit out is the stop bit
			if (bit_count == BIT_COUNT_WIDTH'(FRAME_BITS - 1))
				busy <= 1'b0;
			else
				bit_count <= bit_count + 1'b1;
		end
		else
			period_count <= period_count + 1'b1;
	end

	// Frame shifter, loaded on an accepted write
	always_ff @(posedge clk)
	begin
		if (!busy && tx_enable_i)
			shift_q <= {1'b1, tx_char_i, 1'b0};
		else if (busy && period_done)
			shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
	end

	// Line idles high between frames
	assign tx_o = busy ? shift_q[0] : 1'b1;
	assign tx_ready_o = !busy;

endmodule
